// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int arch_reg_num = 32;
    localparam int phy_reg_num  = 64;
    localparam int arch_reg_w   = $clog2(arch_reg_num);
    localparam int phy_tag_w    = $clog2(phy_reg_num);

    typedef logic [arch_reg_w-1:0] arch_reg_t;
    typedef logic [phy_tag_w-1:0]  phy_tag_t;

    // decoded instruction as it enters rename
    typedef struct packed {
        logic      valid;
        logic      wr_reg;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    // renamed instruction handed to dispatch
    typedef struct packed {
        logic     valid;
        logic     alloc;
        phy_tag_t src1;
        phy_tag_t src2;
        phy_tag_t dst;
        phy_tag_t old_dst;
    } renamed_t;

    // tag given back at commit
    typedef struct packed {
        logic     valid;
        phy_tag_t tag;
    } commit_t;

endpackage

`default_nettype wire

// File: phy_tag_freelist.sv
`timescale 1ns/10ps
`default_nettype none

module phy_tag_freelist (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [1:0]                     need,
    input  wire logic                           accept,
    input  wire rename_pkg::commit_t [1:0]      commit,
    output rename_pkg::phy_tag_t [1:0]          alloc_tag,
    output logic                                stall
);

    rename_pkg::phy_tag_t queue [rename_pkg::phy_reg_num];

    rename_pkg::phy_tag_t head;
    rename_pkg::phy_tag_t tail;
    rename_pkg::phy_tag_t head_plus1;
    rename_pkg::phy_tag_t tail_1;
    logic [rename_pkg::phy_tag_w:0] count;
    logic [rename_pkg::phy_tag_w:0] pop_num;
    logic [rename_pkg::phy_tag_w:0] push_num;

    assign head_plus1 = head + rename_pkg::phy_tag_t'(1);

    // slot 1 takes the head when slot 0 allocates nothing
    assign alloc_tag[0] = queue[head];
    assign alloc_tag[1] = need[0] ? queue[head_plus1] : queue[head];

    assign pop_num  = accept ? need[0] + need[1] : '0;
    assign push_num = commit[0].valid + commit[1].valid;

    // commit[1] lands behind commit[0] when both release
    assign tail_1 = commit[0].valid ? tail + rename_pkg::phy_tag_t'(1) : tail;

    // high below two free tags even when the group needs one
    assign stall = count < 2;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= rename_pkg::phy_tag_t'(rename_pkg::arch_reg_num);
            count <= (rename_pkg::phy_tag_w + 1)'(rename_pkg::arch_reg_num);
        end else begin
            head  <= head + pop_num[rename_pkg::phy_tag_w-1:0];
            tail  <= tail + push_num[rename_pkg::phy_tag_w-1:0];
            count <= count - pop_num + push_num;
        end
    end

    // tags above the architectural range start out free and in order
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::arch_reg_num; i++) begin
                queue[i] <= rename_pkg::phy_tag_t'(i + rename_pkg::arch_reg_num);
            end
        end else begin
            if (commit[0].valid) begin
                queue[tail] <= commit[0].tag;
            end
            if (commit[1].valid) begin
                queue[tail_1] <= commit[1].tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: rename_map_table.sv
`timescale 1ns/10ps
`default_nettype none

module rename_map_table (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire rename_pkg::rename_req_t [1:0]  req,
    input  wire logic [1:0]                     we,
    input  wire rename_pkg::phy_tag_t [1:0]     wtag,
    output rename_pkg::phy_tag_t [1:0]          src1_map,
    output rename_pkg::phy_tag_t [1:0]          src2_map,
    output rename_pkg::phy_tag_t [1:0]          dst_map
);

    rename_pkg::phy_tag_t map [rename_pkg::arch_reg_num];

    // in-group bypass is left to rename_logic
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src1_map[i] = map[req[i].rs1];
            src2_map[i] = map[req[i].rs2];
            dst_map[i]  = map[req[i].rd];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // identity mapping out of reset
            for (int i = 0; i < rename_pkg::arch_reg_num; i++) begin
                map[i] <= rename_pkg::phy_tag_t'(i);
            end
        end else begin
            // slot 1 is younger so its write goes last and wins
            for (int i = 0; i < 2; i++) begin
                if (we[i]) begin
                    map[req[i].rd] <= wtag[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rename_logic.sv
`timescale 1ns/10ps
`default_nettype none

module rename_logic (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire rename_pkg::rename_req_t [1:0]  req,
    input  wire logic                           stall,
    input  wire rename_pkg::phy_tag_t [1:0]     alloc_tag,
    input  wire rename_pkg::phy_tag_t [1:0]     src1_map,
    input  wire rename_pkg::phy_tag_t [1:0]     src2_map,
    input  wire rename_pkg::phy_tag_t [1:0]     dst_map,
    output logic [1:0]                          need,
    output logic                                accept,
    output rename_pkg::renamed_t [1:0]          renamed
);

    rename_pkg::renamed_t [1:0] renamed_d;
    logic fwd_rs1;
    logic fwd_rs2;
    logic waw;

    // x0 never gets a tag
    assign need[0] = req[0].valid & req[0].wr_reg & (req[0].rd != '0);
    assign need[1] = req[1].valid & req[1].wr_reg & (req[1].rd != '0);

    assign accept = ~stall & (req[0].valid | req[1].valid);

    // slot 1 depends on slot 0 within the same group
    assign fwd_rs1 = need[0] & (req[1].rs1 == req[0].rd);
    assign fwd_rs2 = need[0] & (req[1].rs2 == req[0].rd);
    assign waw     = need[0] & (req[1].rd == req[0].rd);

    always_comb begin
        renamed_d[0].valid   = req[0].valid;
        renamed_d[0].alloc   = need[0];
        renamed_d[0].src1    = src1_map[0];
        renamed_d[0].src2    = src2_map[0];
        renamed_d[0].dst     = need[0] ? alloc_tag[0] : '0;
        renamed_d[0].old_dst = need[0] ? dst_map[0] : '0;

        renamed_d[1].valid   = req[1].valid;
        renamed_d[1].alloc   = need[1];
        renamed_d[1].src1    = fwd_rs1 ? alloc_tag[0] : src1_map[1];
        renamed_d[1].src2    = fwd_rs2 ? alloc_tag[0] : src2_map[1];
        renamed_d[1].dst     = need[1] ? alloc_tag[1] : '0;
        renamed_d[1].old_dst = '0;
        if (need[1]) begin
            // on WAW the previous mapping is slot 0's fresh tag
            renamed_d[1].old_dst = waw ? alloc_tag[0] : dst_map[1];
        end
    end

    always_ff @(posedge clk) begin
        renamed <= renamed_d;
        if (reset || stall) begin
            for (int i = 0; i < 2; i++) begin
                renamed[i].valid <= 1'b0;
                renamed[i].alloc <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rename_unit (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire rename_pkg::rename_req_t [1:0]  req,
    input  wire rename_pkg::commit_t [1:0]      commit,
    output wire rename_pkg::renamed_t [1:0]     renamed,
    output wire                                 stall
);

    wire rename_pkg::phy_tag_t [1:0] alloc_tag;
    wire rename_pkg::phy_tag_t [1:0] src1_map;
    wire rename_pkg::phy_tag_t [1:0] src2_map;
    wire rename_pkg::phy_tag_t [1:0] dst_map;
    wire [1:0]                       need;
    wire                             accept;
    wire [1:0]                       we;

    // table only moves on an accepted group
    assign we = need & {2{accept}};

    phy_tag_freelist u_freelist (
        .clk       (clk),
        .reset     (reset),
        .need      (need),
        .accept    (accept),
        .commit    (commit),
        .alloc_tag (alloc_tag),
        .stall     (stall)
    );

    rename_map_table u_map_table (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .we       (we),
        .wtag     (alloc_tag),
        .src1_map (src1_map),
        .src2_map (src2_map),
        .dst_map  (dst_map)
    );

    rename_logic u_rename_logic (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .stall     (stall),
        .alloc_tag (alloc_tag),
        .src1_map  (src1_map),
        .src2_map  (src2_map),
        .dst_map   (dst_map),
        .need      (need),
        .accept    (accept),
        .renamed   (renamed)
    );

endmodule

`default_nettype wire

// File: tb_rename_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_assertions (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire logic                        stall,
    input wire rename_pkg::renamed_t [1:0]  renamed
);

    // two allocations in one group never share a tag
    distinct_tags: assert property (
        @(posedge clk) disable iff (reset)
        (renamed[0].alloc && renamed[1].alloc) |-> (renamed[0].dst != renamed[1].dst)
    ) else $error("both slots received tag %0d", renamed[0].dst);

    stall_clears_valid: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> !(renamed[0].valid || renamed[1].valid)
    ) else $error("renamed valid set after a stalled cycle");

    reset_clears_valid: assert property (
        @(posedge clk)
        reset |=> !(renamed[0].valid || renamed[1].valid)
    ) else $error("renamed valid set after reset");

endmodule

bind rename_unit tb_rename_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .renamed (renamed)
);

`default_nettype wire

// File: tb_rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_unit;

    localparam int clk_period   = 4;
    localparam int num_random   = 400;
    localparam int num_directed = 80;
    // eight cycles per group, plus reset and drain
    localparam int watchdog_cycles = (num_random + num_directed) * 8 + 100;

    typedef struct packed {
        rename_pkg::renamed_t [1:0] grp;
        logic                       stall;
    } expect_t;

    logic                           clk;
    logic                           reset;
    rename_pkg::rename_req_t [1:0]  req;
    rename_pkg::commit_t [1:0]      commit;
    rename_pkg::renamed_t [1:0]     renamed;
    logic                           stall;

    // reference state
    rename_pkg::phy_tag_t           model_map [rename_pkg::arch_reg_num];
    rename_pkg::phy_tag_t           model_free [$];
    rename_pkg::phy_tag_t           released [$];
    rename_pkg::rename_req_t [1:0]  cur_req;
    rename_pkg::commit_t [1:0]      cur_commit;
    expect_t                        expect_q [$];

    int seed = 29337;
    int renamed_errors = 0;
    int stall_errors = 0;

    rename_unit u_rename_unit (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .commit  (commit),
        .renamed (renamed),
        .stall   (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic void model_init();
        model_free.delete();
        released.delete();
        for (int i = 0; i < rename_pkg::arch_reg_num; i++) begin
            model_map[i] = rename_pkg::phy_tag_t'(i);
            model_free.push_back(rename_pkg::phy_tag_t'(i + rename_pkg::arch_reg_num));
        end
    endfunction

    // older slot first, so in-group bypass and WAW fall out of the map update
    function automatic void predict_group(input rename_pkg::rename_req_t [1:0] r,
                                          output rename_pkg::renamed_t [1:0] want);
        logic need;
        want = '0;
        if (model_free.size() < 2 || !(r[0].valid || r[1].valid)) begin
            return;
        end
        for (int i = 0; i < 2; i++) begin
            need = r[i].valid && r[i].wr_reg && (r[i].rd != 0);
            want[i].valid = r[i].valid;
            if (r[i].valid) begin
                want[i].alloc = need;
                want[i].src1  = model_map[r[i].rs1];
                want[i].src2  = model_map[r[i].rs2];
                if (need) begin
                    want[i].dst     = model_free.pop_front();
                    want[i].old_dst = model_map[r[i].rd];
                    model_map[r[i].rd] = want[i].dst;
                    released.push_back(want[i].old_dst);
                end
            end
        end
    endfunction

    function automatic void apply_edge();
        expect_t e;
        predict_group(cur_req, e.grp);
        for (int i = 0; i < 2; i++) begin
            if (cur_commit[i].valid) begin
                model_free.push_back(cur_commit[i].tag);
            end
        end
        e.stall = model_free.size() < 2;
        expect_q.push_back(e);
    endfunction

    function automatic rename_pkg::rename_req_t make_req(input logic wr_reg, input int rs1,
                                                         input int rs2, input int rd);
        rename_pkg::rename_req_t r;
        r.valid  = 1'b1;
        r.wr_reg = wr_reg;
        r.rs1    = rename_pkg::arch_reg_t'(rs1);
        r.rs2    = rename_pkg::arch_reg_t'(rs2);
        r.rd     = rename_pkg::arch_reg_t'(rd);
        return r;
    endfunction

    function automatic rename_pkg::rename_req_t rand_req();
        rename_pkg::rename_req_t r;
        r.valid  = ($random(seed) & 7) != 0;
        r.wr_reg = ($random(seed) & 3) != 0;
        // narrow register range keeps dependencies frequent
        r.rs1    = rename_pkg::arch_reg_t'($random(seed) & 7);
        r.rs2    = rename_pkg::arch_reg_t'($random(seed) & 7);
        r.rd     = rename_pkg::arch_reg_t'($random(seed) & 7);
        return r;
    endfunction

    // mask 0 releases whenever a tag is waiting
    function automatic void take_released(input int mask,
                                          output rename_pkg::commit_t [1:0] c);
        c = '0;
        for (int i = 0; i < 2; i++) begin
            if (released.size() > 0 && ($random(seed) & mask) == 0) begin
                c[i].valid = 1'b1;
                c[i].tag   = released.pop_front();
            end
        end
    endfunction

    // done is set when the driven group leaves at the next edge
    task automatic step_cycle(input rename_pkg::rename_req_t [1:0] r,
                              input rename_pkg::commit_t [1:0] c, output logic done);
        @(posedge clk);
        apply_edge();
        req <= r;
        commit <= c;
        cur_req = r;
        cur_commit = c;
        done = model_free.size() >= 2 || !(r[0].valid || r[1].valid);
    endtask

    function automatic string fmt_renamed(input rename_pkg::renamed_t r);
        return $sformatf("v=%b a=%b src1=%0d src2=%0d dst=%0d old_dst=%0d",
                         r.valid, r.alloc, r.src1, r.src2, r.dst, r.old_dst);
    endfunction

    task automatic check_renamed(input int slot, input rename_pkg::renamed_t got,
                                 input rename_pkg::renamed_t want);
        if (!want.valid) begin
            // fields of an empty slot carry no meaning
            if (got.valid !== 1'b0) begin
                renamed_errors++;
                $display("mismatch at %0t: renamed[%0d].valid expected 0 got %b",
                         $time, slot, got.valid);
            end
        end else if (got !== want) begin
            renamed_errors++;
            $display("mismatch at %0t: renamed[%0d] expected %s got %s",
                     $time, slot, fmt_renamed(want), fmt_renamed(got));
        end
    endtask

    task automatic check_stall(input logic got, input logic want);
        if (got !== want) begin
            stall_errors++;
            $display("mismatch at %0t: stall expected %b got %b", $time, want, got);
        end
    endtask

    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (expect_q.size() > 0) begin
                e = expect_q.pop_front();
                check_renamed(0, renamed[0], e.grp[0]);
                check_renamed(1, renamed[1], e.grp[1]);
                check_stall(stall, e.stall);
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d cycles, the stimulus never finished", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        rename_pkg::rename_req_t [1:0] grp;
        rename_pkg::commit_t [1:0] rel;
        logic done;

        reset = 1'b1;
        req = '0;
        commit = '0;
        cur_req = '0;
        cur_commit = '0;
        model_init();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // independent groups take 32 and up
        grp[0] = make_req(1'b1, 1, 2, 3);
        grp[1] = make_req(1'b1, 4, 5, 6);
        step_cycle(grp, '0, done);
        grp[0] = make_req(1'b1, 7, 8, 9);
        grp[1] = make_req(1'b1, 10, 11, 12);
        step_cycle(grp, '0, done);

        // slot 1 reads slot 0's rd
        grp[0] = make_req(1'b1, 1, 2, 5);
        grp[1] = make_req(1'b1, 5, 5, 6);
        step_cycle(grp, '0, done);

        // WAW on x7, then x7 is read
        grp[0] = make_req(1'b1, 3, 4, 7);
        grp[1] = make_req(1'b1, 7, 3, 7);
        step_cycle(grp, '0, done);
        grp[0] = make_req(1'b1, 7, 7, 8);
        grp[1] = make_req(1'b0, 7, 0, 9);
        step_cycle(grp, '0, done);

        // no destination
        grp[0] = make_req(1'b0, 1, 2, 10);
        grp[1] = make_req(1'b1, 3, 4, 0);
        step_cycle(grp, '0, done);
        grp[0] = make_req(1'b1, 10, 0, 11);
        grp[1] = make_req(1'b1, 0, 11, 12);
        step_cycle(grp, '0, done);

        // drain the freelist, then free it through commit
        grp[0] = make_req(1'b1, 1, 2, 13);
        grp[1] = make_req(1'b1, 13, 3, 14);
        done = 1'b1;
        while (done) begin
            step_cycle(grp, '0, done);
        end
        take_released(0, rel);
        step_cycle(grp, rel, done);
        while (!done) begin
            step_cycle(grp, '0, done);
        end

        for (int n = 0; n < num_random; n++) begin
            if (done) begin
                grp[0] = rand_req();
                grp[1] = rand_req();
            end
            take_released(1, rel);
            step_cycle(grp, rel, done);
        end

        grp = '0;
        step_cycle(grp, '0, done);
        step_cycle(grp, '0, done);
        @(negedge clk);
        @(posedge clk);
        $display("errors: renamed %0d, stall %0d", renamed_errors, stall_errors);
        if (renamed_errors == 0 && stall_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rename_pkg.sv
phy_tag_freelist.sv
rename_map_table.sv
rename_logic.sv
rename_unit.sv
tb_rename_assertions.sv
tb_rename_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rename unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_unit -f compile.f -o sim_rename
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_rename > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
